//--- hdl/issuePkg.sv
`default_nettype none

package issuePkg;

	// Widths with a meaning of their own
	typedef logic [31:0] wordT;
	typedef logic [4:0]  regAddrT;
	typedef logic [11:0] csrAddrT;
	typedef logic [3:0]  aluFnT;
	typedef logic [3:0]  memOpT;
	typedef logic [1:0]  bSelT;

	////////////////////
	// Memory operation codes

	// Zero is no access, codes with the top bit clear are loads
	localparam memOpT MEM_NONE = 4'd0;

	////////////////////
	// Operand B select

	localparam bSelT BSEL_REG   = 2'd0;
	localparam bSelT BSEL_IMM   = 2'd1;
	localparam bSelT BSEL_SHAMT = 2'd2;

	////////////////////
	// Machine CSR addresses

	localparam csrAddrT CSR_MSTATUS  = 12'h300;
	localparam csrAddrT CSR_MTVEC    = 12'h305;
	localparam csrAddrT CSR_MSCRATCH = 12'h340;
	localparam csrAddrT CSR_MEPC     = 12'h341;
	localparam csrAddrT CSR_MCAUSE   = 12'h342;

	// Global interrupt enable in mstatus
	localparam int MSTATUS_MIE_BIT = 3;

endpackage

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
	import issuePkg::*;
(
	input  logic    clk,
	input  logic    nrst,
	input  logic    we,
	input  regAddrT wAddr,
	input  wordT    wData,
	input  regAddrT rAddrA,
	input  regAddrT rAddrB,
	output wordT    rDataA,
	output wordT    rDataB
);

	// No storage behind x0
	wordT regs [1:31];

	always_ff @(posedge clk)
	begin
		if (we && (wAddr != '0))
			regs[wAddr] <= wData;
	end

	// Write-first: a write strobe in flight wins over the array
	function automatic wordT readPort(input regAddrT addr);
		if (addr == '0)
			return '0;
		if (we && (wAddr == addr))
			return wData;
		return regs[addr];
	endfunction

	always_comb
	begin
		rDataA = readPort(rAddrA);
		rDataB = readPort(rAddrB);
	end

	// A register written by commit reads back on the next cycle unless written again
	writeReadBack: assert property (@(posedge clk) disable iff (!nrst)
		(we && (wAddr != '0)) |=> ((rAddrA != $past(wAddr)) || (we && (wAddr == rAddrA))
			|| (rDataA == $past(wData))));

endmodule

`default_nettype wire

//--- hdl/hazardScoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module hazardScoreboard
	import issuePkg::*;
(
	input  logic    clk,
	input  logic    nrst,
	input  logic    decValid,
	input  regAddrT decRs1,
	input  regAddrT decRs2,
	input  regAddrT issRd,
	input  memOpT   issMemOp,
	input  logic    issWe,
	input  logic    branchTaken,
	input  logic    stallMem,
	output logic    stall,
	output logic    kill
);

	typedef enum logic [1:0] {KILL_IDLE, KILL_FIRST, KILL_SECOND} killStateT;

	killStateT killState;
	killStateT killPhase;
	logic      issIsLoad;
	logic      srcMatch;

	////////////////////
	// Load-use detection

	// Load in the issue slot that really writes a register
	assign issIsLoad = (issMemOp != MEM_NONE) && !issMemOp[3] && issWe && (issRd != '0);
	assign srcMatch  = (issRd == decRs1) || (issRd == decRs2);

	// Slot is frozen under memory hold, so the load cannot move on anyway
	assign stall = decValid && issIsLoad && srcMatch && !stallMem;

	////////////////////
	// Branch kill FSM

	// First squash lands on the branch's own edge, hence combinational
	assign killPhase = branchTaken ? KILL_FIRST : killState;
	assign kill      = (killPhase != KILL_IDLE);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			killState <= KILL_IDLE;
		else
		begin
			case (killPhase)
				KILL_FIRST:
					killState <= KILL_SECOND;
				default:
					killState <= KILL_IDLE;
			endcase
		end
	end

	// Bubble loaded by the issue register clears the hazard after one cycle
	stallOneCycle: assert property (@(posedge clk) disable iff (!nrst)
		(stall && !stallMem) |=> !stall);

endmodule

`default_nettype wire

//--- hdl/csrFile.sv
`timescale 1ns/1ps
`default_nettype none

module csrFile
	import issuePkg::*;
#(
	parameter wordT RESET_VECTOR = 32'h0000_0000
)
(
	input  logic    clk,
	input  logic    nrst,
	input  csrAddrT rAddr,
	output wordT    rData,
	input  logic    we,
	input  csrAddrT wAddr,
	input  wordT    wData,
	input  logic    excPending,
	input  wordT    excCause,
	input  wordT    excPc,
	input  logic    mretPulse,
	output wordT    epc,
	output wordT    trapVector,
	output logic    mie
);

	wordT mstatus;
	wordT mtvec;
	wordT mepc;
	wordT mcause;
	wordT mscratch;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mstatus  <= '0;
			mtvec    <= RESET_VECTOR;
			mepc     <= '0;
			mcause   <= '0;
			mscratch <= '0;
		end
		else
		begin
			// CSR instruction retired by commit
			if (we)
			begin
				case (wAddr)
					CSR_MSTATUS:  mstatus  <= wData;
					CSR_MTVEC:    mtvec    <= wData;
					CSR_MEPC:     mepc     <= wData;
					CSR_MCAUSE:   mcause   <= wData;
					CSR_MSCRATCH: mscratch <= wData;
					default:      ;
				endcase
			end
			// Trap entry and return take precedence over that write
			if (excPending)
			begin
				mepc                     <= excPc;
				mcause                   <= excCause;
				mstatus[MSTATUS_MIE_BIT] <= 1'b0;
			end
			else if (mretPulse)
				mstatus[MSTATUS_MIE_BIT] <= 1'b1;
		end
	end

	always_comb
	begin
		case (rAddr)
			CSR_MSTATUS:  rData = mstatus;
			CSR_MTVEC:    rData = mtvec;
			CSR_MEPC:     rData = mepc;
			CSR_MCAUSE:   rData = mcause;
			CSR_MSCRATCH: rData = mscratch;
			default:      rData = '0;
		endcase
	end

	// To the front end
	assign epc        = mepc;
	assign trapVector = mtvec;
	assign mie        = mstatus[MSTATUS_MIE_BIT];

	// Commit retires at most one trap or return per cycle
	oneTrapEvent: assert property (@(posedge clk) disable iff (!nrst)
		!(excPending && mretPulse));

endmodule

`default_nettype wire

//--- hdl/issueRegister.sv
`timescale 1ns/1ps
`default_nettype none

module issueRegister
	import issuePkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	// Decode fields
	input  logic       decValid,
	input  logic       decWe,
	input  regAddrT    decRd,
	input  regAddrT    decRs1,
	input  regAddrT    decRs2,
	input  bSelT       decBSel,
	input  aluFnT      decAluFn,
	input  logic [2:0] decFn3,
	input  memOpT      decMemOp,
	input  wordT       decImm,
	input  logic [4:0] decShamt,
	input  wordT       decPc,
	input  csrAddrT    decCsrAddr,
	input  logic       decCsrWe,
	// Slot control
	input  logic       stall,
	input  logic       kill,
	input  logic       stallMem,
	input  wordT       rDataB,
	// Issue slot
	output logic       issValid,
	output logic       issWe,
	output regAddrT    issRd,
	output regAddrT    issRs1,
	output regAddrT    issRs2,
	output aluFnT      issAluFn,
	output logic [2:0] issFn3,
	output memOpT      issMemOp,
	output wordT       issImm,
	output wordT       issPc,
	output csrAddrT    issCsrAddr,
	output logic       issCsrWe,
	output wordT       opB
);

	bSelT       bSel;
	logic [4:0] shamt;
	logic       loadBubble;

	// Kill beats memory hold, which beats the load-use bubble
	assign loadBubble = kill || (stall && !stallMem);

	////////////////////
	// Control fields

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			issValid <= 1'b0;
			issWe    <= 1'b0;
			issCsrWe <= 1'b0;
			issMemOp <= MEM_NONE;
			issRd    <= '0;
			bSel     <= BSEL_IMM;
		end
		else if (loadBubble)
		begin
			issValid <= 1'b0;
			issWe    <= 1'b0;
			issCsrWe <= 1'b0;
			issMemOp <= MEM_NONE;
			issRd    <= '0;
			bSel     <= BSEL_IMM;
		end
		else if (!stallMem)
		begin
			// Side effects only for a real instruction
			issValid <= decValid;
			issWe    <= decWe && decValid;
			issCsrWe <= decCsrWe && decValid;
			issMemOp <= decValid ? decMemOp : MEM_NONE;
			issRd    <= decRd;
			bSel     <= decBSel;
		end
	end

	////////////////////
	// Payload fields

	always_ff @(posedge clk)
	begin
		if (loadBubble)
		begin
			issRs1     <= '0;
			issRs2     <= '0;
			issAluFn   <= '0;
			issFn3     <= '0;
			issImm     <= '0;
			shamt      <= '0;
			issPc      <= '0;
			issCsrAddr <= '0;
		end
		else if (!stallMem)
		begin
			issRs1     <= decRs1;
			issRs2     <= decRs2;
			issAluFn   <= decAluFn;
			issFn3     <= decFn3;
			issImm     <= decImm;
			shamt      <= decShamt;
			issPc      <= decPc;
			issCsrAddr <= decCsrAddr;
		end
	end

	// Operand B source
	always_comb
	begin
		case (bSel)
			BSEL_IMM:   opB = issImm;
			BSEL_SHAMT: opB = {27'b0, shamt};
			default:    opB = rDataB;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/issueUnit.sv
`timescale 1ns/1ps
`default_nettype none

module issueUnit
	import issuePkg::*;
#(
	parameter wordT RESET_VECTOR = 32'h0000_0080
)
(
	input  logic       clk,
	input  logic       nrst,
	// From decode
	input  logic       decValid, decWe, decCsrWe,
	input  regAddrT    decRd, decRs1, decRs2,
	input  bSelT       decBSel,
	input  aluFnT      decAluFn,
	input  logic [2:0] decFn3,
	input  memOpT      decMemOp,
	input  wordT       decImm, decPc,
	input  logic [4:0] decShamt,
	input  csrAddrT    decCsrAddr,
	// From commit
	input  logic       wbWe, csrWe, excPending, mretPulse,
	input  regAddrT    wbAddr,
	input  wordT       wbData, csrWbData, excCause, excPc,
	input  csrAddrT    csrWbAddr,
	// From execute
	input  logic       branchTaken, stallMem,
	// To execute
	output logic       issValid, issWe, issCsrWe,
	output regAddrT    issRd, issRs1, issRs2,
	output aluFnT      issAluFn,
	output logic [2:0] issFn3,
	output memOpT      issMemOp,
	output wordT       issImm, issPc,
	output csrAddrT    issCsrAddr,
	output wordT       opA, opB, csrData,
	// To front end and decode
	output wordT       epc, trapVector,
	output logic       mie, stall
);

	logic kill;
	wordT rDataB;

	// Operands read at the registered sources
	registerFile registerFile_i (
		.clk(clk),
		.nrst(nrst),
		.we(wbWe),
		.wAddr(wbAddr),
		.wData(wbData),
		.rAddrA(issRs1),
		.rAddrB(issRs2),
		.rDataA(opA),
		.rDataB(rDataB)
	);

	hazardScoreboard hazardScoreboard_i (.*);

	issueRegister issueRegister_i (.*);

	csrFile #(
		.RESET_VECTOR(RESET_VECTOR)
	) csrFile_i (
		.*,
		.rAddr(issCsrAddr),
		.rData(csrData),
		.we(csrWe),
		.wAddr(csrWbAddr),
		.wData(csrWbData)
	);

endmodule

`default_nettype wire

//--- verification/issueUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module issueUnitTb
	import issuePkg::*;
();

	localparam int   CLK_PERIOD   = 4;
	localparam int   NUM_TESTS    = 2000;
	localparam int   CYCLE_BUDGET = 2;
	localparam wordT RESET_VECTOR = 32'h0000_0200;

	logic       clk, nrst;
	logic       decValid, decWe, decCsrWe;
	regAddrT    decRd, decRs1, decRs2;
	bSelT       decBSel;
	aluFnT      decAluFn;
	logic [2:0] decFn3;
	memOpT      decMemOp;
	wordT       decImm, decPc;
	logic [4:0] decShamt;
	csrAddrT    decCsrAddr;
	logic       wbWe, csrWe, excPending, mretPulse, branchTaken, stallMem;
	regAddrT    wbAddr;
	wordT       wbData, csrWbData, excCause, excPc;
	csrAddrT    csrWbAddr;
	logic       issValid, issWe, issCsrWe, mie, stall;
	regAddrT    issRd, issRs1, issRs2;
	aluFnT      issAluFn;
	logic [2:0] issFn3;
	memOpT      issMemOp;
	wordT       issImm, issPc, opA, opB, csrData, epc, trapVector;
	csrAddrT    issCsrAddr;

	////////////////////
	// Reference model state

	logic [31:0] lcgState;
	string       testName;
	wordT        shadowReg [0:31];
	wordT        mstatusM, mtvecM, mepcM, mcauseM, mscratchM;
	logic        sValid, sWe, sCsrWe, killPending, decHold;
	memOpT       sMemOp;
	regAddrT     sRd, sRs1, sRs2;
	bSelT        sBSel;
	aluFnT       sAluFn;
	logic [2:0]  sFn3;
	wordT        sImm, sPc;
	logic [4:0]  sShamt;
	csrAddrT     sCsrAddr;

	issueUnit #(
		.RESET_VECTOR(RESET_VECTOR)
	) issueUnit_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic wordT nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Mostly x0..x7 so that sources and destinations collide often
	function automatic regAddrT pickReg();
		wordT rnd;
		rnd = nextRand();
		if (rnd[31:30] == 2'b00)
			return rnd[29:25];
		return {2'b00, rnd[29:27]};
	endfunction

	function automatic csrAddrT pickCsr();
		wordT rnd;
		rnd = nextRand();
		case (rnd[31:29])
			3'd0, 3'd5: return CSR_MSTATUS;
			3'd1:       return CSR_MTVEC;
			3'd2, 3'd6: return CSR_MEPC;
			3'd3:       return CSR_MCAUSE;
			3'd4:       return CSR_MSCRATCH;
			default:    return 12'h7c0;
		endcase
	endfunction

	// Commit write in the same cycle is seen by the read
	function automatic wordT regRead(input regAddrT addr);
		if (addr == 5'd0)
			return '0;
		if (wbWe && (wbAddr == addr))
			return wbData;
		return shadowReg[addr];
	endfunction

	function automatic wordT csrRead(input csrAddrT addr);
		case (addr)
			CSR_MSTATUS:  return mstatusM;
			CSR_MTVEC:    return mtvecM;
			CSR_MEPC:     return mepcM;
			CSR_MCAUSE:   return mcauseM;
			CSR_MSCRATCH: return mscratchM;
			default:      return '0;
		endcase
	endfunction

	// Load in the slot that writes a nonzero rd read by decode
	function automatic logic loadUseStall();
		logic slotLoad;
		slotLoad = (sMemOp != 4'd0) && !sMemOp[3] && sWe && (sRd != 5'd0);
		return decValid && !stallMem && slotLoad && ((sRd == decRs1) || (sRd == decRs2));
	endfunction

	function automatic wordT expectedOpB();
		case (sBSel)
			BSEL_IMM:   return sImm;
			BSEL_SHAMT: return {27'd0, sShamt};
			default:    return regRead(sRs2);
		endcase
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkWord(input string what, input wordT expected, input wordT actual);
		if (actual !== expected)
			failRun($sformatf("Error %s %s: expected %h, actual %h",
				testName, what, expected, actual));
	endtask

	task automatic checkReg(input string what, input regAddrT expected, input regAddrT actual);
		if (actual !== expected)
			failRun($sformatf("Error %s %s: expected %0d, actual %0d",
				testName, what, expected, actual));
	endtask

	task automatic checkCode(input string what, input aluFnT expected, input aluFnT actual);
		if (actual !== expected)
			failRun($sformatf("Error %s %s: expected %h, actual %h",
				testName, what, expected, actual));
	endtask

	task automatic checkCsrAddr(input string what, input csrAddrT expected,
		input csrAddrT actual);
		if (actual !== expected)
			failRun($sformatf("Error %s %s: expected %h, actual %h",
				testName, what, expected, actual));
	endtask

	task automatic checkBit(input string what, input logic expected, input logic actual);
		if (actual !== expected)
			failRun($sformatf("Error %s %s: expected %b, actual %b",
				testName, what, expected, actual));
	endtask

	task automatic clearSlot();
		sValid   = 1'b0;
		sWe      = 1'b0;
		sCsrWe   = 1'b0;
		sMemOp   = 4'd0;
		sRd      = 5'd0;
		sBSel    = BSEL_IMM;
		sRs1     = 5'd0;
		sRs2     = 5'd0;
		sAluFn   = 4'd0;
		sFn3     = 3'd0;
		sImm     = '0;
		sShamt   = 5'd0;
		sPc      = '0;
		sCsrAddr = 12'd0;
	endtask

	// Effect of one rising edge on the model, from the inputs before it
	task automatic applyEdge();
		logic stallNow;
		logic killNow;
		stallNow = loadUseStall();
		killNow  = branchTaken || killPending;
		decHold  = stallMem || stallNow;
		// Kill first, then memory hold, then load-use bubble
		if (killNow || stallNow)
			clearSlot();
		else if (!stallMem)
		begin
			// An invalid decode slot carries no side effects
			sValid   = decValid;
			sWe      = decWe && decValid;
			sCsrWe   = decCsrWe && decValid;
			sMemOp   = decValid ? decMemOp : 4'd0;
			sRd      = decRd;
			sBSel    = decBSel;
			sRs1     = decRs1;
			sRs2     = decRs2;
			sAluFn   = decAluFn;
			sFn3     = decFn3;
			sImm     = decImm;
			sShamt   = decShamt;
			sPc      = decPc;
			sCsrAddr = decCsrAddr;
		end
		killPending = branchTaken;
		if (wbWe && (wbAddr != 5'd0))
			shadowReg[wbAddr] = wbData;
		if (csrWe)
		begin
			case (csrWbAddr)
				CSR_MSTATUS:  mstatusM  = csrWbData;
				CSR_MTVEC:    mtvecM    = csrWbData;
				CSR_MEPC:     mepcM     = csrWbData;
				CSR_MCAUSE:   mcauseM   = csrWbData;
				CSR_MSCRATCH: mscratchM = csrWbData;
				default:      ;
			endcase
		end
		if (excPending)
		begin
			mepcM                     = excPc;
			mcauseM                   = excCause;
			mstatusM[MSTATUS_MIE_BIT] = 1'b0;
		end
		else if (mretPulse)
			mstatusM[MSTATUS_MIE_BIT] = 1'b1;
	endtask

	// Decode keeps its instruction while stalled or under memory hold
	task automatic driveDecode();
		wordT rnd;
		rnd = nextRand();
		if (!decHold)
		begin
			decValid   <= rnd[31] | rnd[30];
			decWe      <= rnd[29] | rnd[28];
			decCsrWe   <= (rnd[27:25] == 3'd0);
			decBSel    <= rnd[24:23];
			decAluFn   <= rnd[22:19];
			decFn3     <= rnd[18:16];
			decShamt   <= rnd[15:11];
			decMemOp   <= rnd[10] ? rnd[9:6] : 4'd0;
			decRd      <= pickReg();
			decRs1     <= pickReg();
			decRs2     <= pickReg();
			decImm     <= nextRand();
			decPc      <= nextRand() & 32'hffff_fffc;
			decCsrAddr <= pickCsr();
		end
	endtask

	task automatic driveCommit();
		wordT rnd;
		rnd = nextRand();
		wbWe      <= rnd[31];
		wbAddr    <= pickReg();
		wbData    <= nextRand();
		csrWe     <= (rnd[30:29] == 2'b00);
		csrWbAddr <= pickCsr();
		csrWbData <= nextRand();
		// Trap entry and mret from one field, so never both
		excPending  <= (rnd[28:25] == 4'd0);
		mretPulse   <= (rnd[28:25] == 4'd1);
		excCause    <= {28'd0, rnd[24:21]};
		excPc       <= nextRand() & 32'hffff_fffc;
		branchTaken <= (rnd[20:18] == 3'd0);
		stallMem    <= (rnd[17:15] == 3'd0);
	endtask

	task automatic checkOutputs();
		checkBit("stall", loadUseStall(), stall);
		checkBit("issValid", sValid, issValid);
		checkBit("issWe", sWe, issWe);
		checkBit("issCsrWe", sCsrWe, issCsrWe);
		checkReg("issRd", sRd, issRd);
		checkReg("issRs1", sRs1, issRs1);
		checkReg("issRs2", sRs2, issRs2);
		checkCode("issAluFn", sAluFn, issAluFn);
		checkCode("issFn3", {1'b0, sFn3}, {1'b0, issFn3});
		checkCode("issMemOp", sMemOp, issMemOp);
		checkWord("issImm", sImm, issImm);
		checkWord("issPc", sPc, issPc);
		checkCsrAddr("issCsrAddr", sCsrAddr, issCsrAddr);
		checkWord("opA", regRead(sRs1), opA);
		checkWord("opB", expectedOpB(), opB);
		checkWord("csrData", csrRead(sCsrAddr), csrData);
		checkWord("epc", mepcM, epc);
		checkWord("trapVector", mtvecM, trapVector);
		checkBit("mie", mstatusM[MSTATUS_MIE_BIT], mie);
	endtask

	////////////////////
	// Stimulus

	initial
	begin
		lcgState = 32'h011d_b0cf;
		testName = "reset";
		for (int i = 0; i < 32; i++)
			shadowReg[i] = '0;
		mstatusM    = '0;
		mtvecM      = RESET_VECTOR;
		mepcM       = '0;
		mcauseM     = '0;
		mscratchM   = '0;
		killPending = 1'b0;
		decHold     = 1'b0;
		clearSlot();
		nrst        <= 1'b0;
		decValid    <= 1'b0;
		decWe       <= 1'b0;
		decCsrWe    <= 1'b0;
		decRd       <= 5'd0;
		decRs1      <= 5'd0;
		decRs2      <= 5'd0;
		decBSel     <= BSEL_REG;
		decAluFn    <= 4'd0;
		decFn3      <= 3'd0;
		decMemOp    <= 4'd0;
		decImm      <= '0;
		decPc       <= '0;
		decShamt    <= 5'd0;
		decCsrAddr  <= 12'd0;
		wbWe        <= 1'b0;
		wbAddr      <= 5'd0;
		wbData      <= '0;
		csrWe       <= 1'b0;
		csrWbAddr   <= 12'd0;
		csrWbData   <= '0;
		excPending  <= 1'b0;
		excCause    <= '0;
		excPc       <= '0;
		mretPulse   <= 1'b0;
		branchTaken <= 1'b0;
		stallMem    <= 1'b0;
		repeat (8) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		checkOutputs();

		// Give every register a known value before operands are checked
		testName = "regInit";
		for (int r = 1; r < 32; r++)
		begin
			@(posedge clk);
			applyEdge();
			wbWe   <= 1'b1;
			wbAddr <= 5'(r);
			wbData <= nextRand();
			@(negedge clk);
			checkOutputs();
		end

		testName = "random";
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			@(posedge clk);
			applyEdge();
			driveDecode();
			driveCommit();
			@(negedge clk);
			checkOutputs();
		end
		$display("Verification passed");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * CYCLE_BUDGET * CLK_PERIOD);
		failRun("Watchdog expired before all tests completed");
	end

endmodule

`default_nettype wire

//--- files.f
hdl/issuePkg.sv
hdl/registerFile.sv
hdl/hazardScoreboard.sv
hdl/csrFile.sv
hdl/issueRegister.sv
hdl/issueUnit.sv
verification/issueUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the issue stage testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")"

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module issueUnitTb -f files.f \
	-Mdir "$buildDir" -o issueUnitSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$buildDir/issueUnitSim" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Verification passed" "$logFile"; then
	exit 0
else
	echo "Pass message not found in $logFile"
	exit 1
fi
